//--- common/la_defines.svh
// logic analyzer capture path constants
// probe width, sample buffer geometry and capture window sizes
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

// probe bus and sample width
`define LA_PROBE_W 8

// sample buffer depth in entries
`define LA_FIFO_DEPTH 16

// buffer address and usage width
`define LA_FIFO_AW 4

// samples kept in front of the trigger
`define LA_PRE_DEPTH 8

// samples stored after the trigger sample
`define LA_POST_DEPTH 6

// post counter width, must hold LA_POST_DEPTH - 1
`define LA_POST_CW 3

`endif

//--- common/la_pkg.sv
// logic analyzer shared types
// sample type, trigger modes and capture FSM states
`include "la_defines.svh"

package la_pkg;

    // one probe sample
    typedef logic [`LA_PROBE_W-1:0] sample_t;

    // trigger condition on the masked match state
    typedef enum logic [1:0] {
        TRIG_LEVEL  = 2'd0,
        TRIG_RISE   = 2'd1,
        TRIG_FALL   = 2'd2,
        TRIG_CHANGE = 2'd3
    } trig_mode_e;

    // capture controller states
    typedef enum logic [1:0] {
        LA_IDLE  = 2'd0,
        LA_ARMED = 2'd1,
        LA_POST  = 2'd2,
        LA_DONE  = 2'd3
    } la_state_e;

endpackage

//--- hw/la_fifo_v3.sv
// sample buffer FIFO
// circular buffer with read/write pointers and a status counter,
// optional fall-through, synchronous flush and usage count
`timescale 1ns/1ps
`include "la_defines.svh"

module la_fifo_v3
    import la_pkg::*;
#(
    // head follows data_i when empty and pushing
    parameter bit          FALL_THROUGH = 1'b0,
    // number of entries, must be at least 1
    parameter int unsigned DEPTH        = 8,
    parameter type         dtype        = sample_t
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    output logic                   full_o,
    output logic                   empty_o,
    output logic [`LA_FIFO_AW-1:0] usage_o,
    input  dtype                   data_i,
    input  logic                   push_i,
    output dtype                   data_o,
    input  logic                   pop_i
);

    localparam int unsigned ADDR_DEPTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // last valid pointer value before wrap
    localparam logic [ADDR_DEPTH-1:0] LAST_PTR = ADDR_DEPTH'(DEPTH - 1);

    logic [ADDR_DEPTH-1:0] rd_ptr_q, rd_ptr_d;
    logic [ADDR_DEPTH-1:0] wr_ptr_q, wr_ptr_d;
    // one extra bit so a full buffer is distinct from empty
    logic [ADDR_DEPTH:0]   cnt_q, cnt_d;
    dtype                  mem_q [DEPTH];
    logic                  push_ok;
    logic                  pop_ok;

    // usage is the low part of the status count
    assign usage_o = `LA_FIFO_AW'(cnt_q);

    assign full_o  = (cnt_q == (ADDR_DEPTH+1)'(DEPTH));
    // in fall-through mode a push into an empty buffer is visible at once
    assign empty_o = (cnt_q == '0) & ~(FALL_THROUGH & push_i);

    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;
        data_o   = mem_q[rd_ptr_q];

        if (push_ok) begin
            if (wr_ptr_q == LAST_PTR) begin
                wr_ptr_d = '0;
            end else begin
                wr_ptr_d = wr_ptr_q + 1'b1;
            end
            cnt_d = cnt_q + 1'b1;
        end

        if (pop_ok) begin
            if (rd_ptr_q == LAST_PTR) begin
                rd_ptr_d = '0;
            end else begin
                rd_ptr_d = rd_ptr_q + 1'b1;
            end
            cnt_d = cnt_q - 1'b1;
        end

        // simultaneous push and pop leaves the count alone
        if (push_ok && pop_ok) begin
            cnt_d = cnt_q;
        end

        // bypass path, sample goes straight through without being stored
        if (FALL_THROUGH && (cnt_q == '0) && push_i) begin
            data_o = data_i;
            if (pop_i) begin
                rd_ptr_d = rd_ptr_q;
                wr_ptr_d = wr_ptr_q;
                cnt_d    = cnt_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush wins over any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // storage array, written only on an accepted push
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- hw/la_trigger_unit.sv
// trigger unit
// masked pattern match on the probe with level and edge modes
`timescale 1ns/1ps

module la_trigger_unit
    import la_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  sample_t    probe_i,
    input  sample_t    mask_i,
    input  sample_t    value_i,
    input  trig_mode_e mode_i,
    output logic       hit_o
);

    logic match;
    logic match_q;

    // only bits set in the mask take part in the compare
    assign match = (((probe_i ^ value_i) & mask_i) == '0);

    // previous match state, tracked every clock regardless of capture state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_q <= 1'b0;
        end else begin
            match_q <= match;
        end
    end

    // hit is combinational, valid in the cycle of the sample
    always_comb begin
        case (mode_i)
            TRIG_LEVEL:  hit_o = match;
            // match appears
            TRIG_RISE:   hit_o = match & ~match_q;
            // match goes away
            TRIG_FALL:   hit_o = ~match & match_q;
            TRIG_CHANGE: hit_o = match ^ match_q;
            default:     hit_o = 1'b0;
        endcase
    end

endmodule

//--- hw/la_capture_ctrl.sv
// capture controller
// four-state FSM that keeps a sliding pre-trigger window in the FIFO,
// counts post-trigger samples and gates host reads to DONE
`timescale 1ns/1ps
`include "la_defines.svh"

module la_capture_ctrl
    import la_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   arm_i,
    input  logic                   rd_i,
    input  logic                   hit_i,
    input  logic                   fifo_empty_i,
    input  logic                   fifo_full_i,
    input  logic [`LA_FIFO_AW-1:0] fifo_usage_i,
    output logic                   fifo_push_o,
    output logic                   fifo_pop_o,
    output logic                   fifo_flush_o,
    output logic                   armed_o,
    output logic                   done_o
);

    la_state_e              state_q, state_d;
    logic [`LA_POST_CW-1:0] post_cnt_q, post_cnt_d;
    logic                   window_full;
    logic                   post_last;

    // pre-trigger window holds its maximum number of samples
    assign window_full = (fifo_usage_i == `LA_FIFO_AW'(`LA_PRE_DEPTH));
    // this push completes the post-trigger samples
    assign post_last   = (post_cnt_q == `LA_POST_CW'(`LA_POST_DEPTH - 1));

    always_comb begin
        state_d      = state_q;
        post_cnt_d   = post_cnt_q;
        fifo_push_o  = 1'b0;
        fifo_pop_o   = 1'b0;
        fifo_flush_o = 1'b0;

        if (arm_i) begin
            // arm restarts from any state with an empty buffer
            fifo_flush_o = 1'b1;
            post_cnt_d   = '0;
            state_d      = LA_ARMED;
        end else begin
            case (state_q)
                LA_ARMED: begin
                    fifo_push_o = ~fifo_full_i;
                    if (hit_i) begin
                        // trigger sample stored without dropping the oldest
                        state_d = LA_POST;
                    end else if (window_full) begin
                        // slide window, drop oldest as the new one goes in
                        fifo_pop_o = 1'b1;
                    end
                end
                LA_POST: begin
                    fifo_push_o = ~fifo_full_i;
                    post_cnt_d  = post_cnt_q + 1'b1;
                    if (post_last) begin
                        state_d = LA_DONE;
                    end
                end
                LA_DONE: begin
                    // buffer frozen, host pops one entry per rd pulse
                    fifo_pop_o = rd_i & ~fifo_empty_i;
                end
                default: begin
                    // idle, wait for arm
                    state_d = LA_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= LA_IDLE;
            post_cnt_q <= '0;
        end else begin
            state_q    <= state_d;
            post_cnt_q <= post_cnt_d;
        end
    end

    // capturing covers both the pre- and post-trigger phases
    assign armed_o = (state_q == LA_ARMED) || (state_q == LA_POST);
    assign done_o  = (state_q == LA_DONE);

endmodule

//--- hw/la_capture_top.sv
// logic analyzer capture path
// trigger unit, sample buffer and capture controller
`timescale 1ns/1ps
`include "la_defines.svh"

module la_capture_top
    import la_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  sample_t                probe_i,
    input  sample_t                mask_i,
    input  sample_t                value_i,
    input  trig_mode_e             mode_i,
    input  logic                   arm_i,
    input  logic                   rd_i,
    output logic                   armed_o,
    output logic                   done_o,
    output logic                   rd_empty_o,
    output sample_t                rd_data_o,
    output logic [`LA_FIFO_AW-1:0] rd_count_o
);

    logic trig_hit;
    logic fifo_push;
    logic fifo_pop;
    logic fifo_flush;
    logic fifo_full;

    la_trigger_unit u_trigger (
        .clk     (clk),
        .rst_n   (rst_n),
        .probe_i (probe_i),
        .mask_i  (mask_i),
        .value_i (value_i),
        .mode_i  (mode_i),
        .hit_o   (trig_hit)
    );

    // registered head, the probe feeds the buffer directly
    la_fifo_v3 #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (`LA_FIFO_DEPTH),
        .dtype        (sample_t)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (fifo_flush),
        .full_o  (fifo_full),
        .empty_o (rd_empty_o),
        .usage_o (rd_count_o),
        .data_i  (probe_i),
        .push_i  (fifo_push),
        .data_o  (rd_data_o),
        .pop_i   (fifo_pop)
    );

    la_capture_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .arm_i        (arm_i),
        .rd_i         (rd_i),
        .hit_i        (trig_hit),
        .fifo_empty_i (rd_empty_o),
        .fifo_full_i  (fifo_full),
        .fifo_usage_i (rd_count_o),
        .fifo_push_o  (fifo_push),
        .fifo_pop_o   (fifo_pop),
        .fifo_flush_o (fifo_flush),
        .armed_o      (armed_o),
        .done_o       (done_o)
    );

endmodule

//--- verif/la_capture_sva.sv
// capture path assertions
// buffer misuse and capture FSM consistency, bound into the FIFO and the controller
`timescale 1ns/1ps

module la_capture_sva
    import la_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      push,
    input logic      pop,
    input logic      full,
    input logic      empty,
    input la_state_e state,
    input logic      armed,
    input logic      done
);

    // a push into a full buffer would be dropped
    a_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push while the FIFO is full");

    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("pop while the FIFO is empty");

    // buffer stays frozen once the capture is complete
    a_push_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && (state == LA_DONE)))
        else $error("push in the DONE state");

    a_done_armed: assert property (@(posedge clk) disable iff (!rst_n) !(done && armed))
        else $error("done_o and armed_o high together");

endmodule

// FIFO view, no FSM behind it
bind la_fifo_v3 la_capture_sva u_fifo_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push_i),
    .pop   (pop_i),
    .full  (full_o),
    .empty (empty_o),
    .state (la_pkg::LA_IDLE),
    .armed (1'b0),
    .done  (1'b0)
);

bind la_capture_ctrl la_capture_sva u_ctrl_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (fifo_push_o),
    .pop   (fifo_pop_o),
    .full  (fifo_full_i),
    .empty (fifo_empty_i),
    .state (state_q),
    .armed (armed_o),
    .done  (done_o)
);

//--- verif/la_capture_tb.sv
// capture path testbench
// table-driven captures checked against a model of the trigger and the sample window
`timescale 1ns/1ps
`include "la_defines.svh"

module la_capture_tb;
    import la_pkg::*;

    // one capture per row with the pattern forced at sample pos after the arm pulse
    typedef struct packed {
        trig_mode_e mode;
        sample_t    mask;
        sample_t    value;
        int         idle;
        int         pos;
        int         abort_at;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    sample_t                probe_i;
    sample_t                mask_i;
    sample_t                value_i;
    trig_mode_e             mode_i;
    logic                   arm_i;
    logic                   rd_i;
    logic                   armed_o;
    logic                   done_o;
    logic                   rd_empty_o;
    sample_t                rd_data_o;
    logic [`LA_FIFO_AW-1:0] rd_count_o;

    row_t       rows [8];
    trig_mode_e cfg_mode;
    sample_t    cfg_mask;
    sample_t    cfg_value;
    // model match state of the sample on the bus now and of the one before
    logic       cur_match;
    logic       prev_match;
    logic       cur_hit;
    sample_t    window [$];
    sample_t    exp_q [$];
    int         checks;
    int         errors;

    la_capture_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_match(input sample_t p, input sample_t m, input sample_t v);
        return (p & m) == (v & m);
    endfunction

    // random sample forced to miss the pattern by flipping the lowest masked bit
    function automatic sample_t miss(input sample_t p);
        sample_t s;
        s = p;
        if (cfg_mask != '0 && is_match(s, cfg_mask, cfg_value)) begin
            s = s ^ (cfg_mask & (~cfg_mask + sample_t'(1)));
        end
        return s;
    endfunction

    function automatic logic model_hit(input logic now_m, input logic was_m);
        case (cfg_mode)
            TRIG_RISE:   return now_m && !was_m;
            TRIG_FALL:   return !now_m && was_m;
            TRIG_CHANGE: return now_m != was_m;
            default:     return now_m;
        endcase
    endfunction

    // inputs change at the rising edge and the trigger model advances one clock
    task automatic step(input sample_t p, input logic arm, input logic rd);
        @(posedge clk);
        prev_match = cur_match;
        probe_i <= p;
        mask_i  <= cfg_mask;
        value_i <= cfg_value;
        mode_i  <= cfg_mode;
        arm_i   <= arm;
        rd_i    <= rd;
        cur_match = is_match(p, cfg_mask, cfg_value);
        cur_hit   = model_hit(cur_match, prev_match);
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [`LA_FIFO_AW-1:0] got,
                               input logic [`LA_FIFO_AW-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    initial begin
        int      errs_at;
        int      n;
        int      cnt;
        logic    got_done;
        sample_t p;
        rows[0] = '{TRIG_LEVEL,  8'hff, 8'h5a, 2, 11, 0};
        rows[1] = '{TRIG_LEVEL,  8'hf0, 8'ha0, 1, 3, 0};
        rows[2] = '{TRIG_RISE,   8'h0f, 8'h06, 3, 9, 0};
        rows[3] = '{TRIG_FALL,   8'hff, 8'h3c, 1, 5, 0};
        rows[4] = '{TRIG_CHANGE, 8'h3c, 8'h24, 2, 0, 0};
        // row 5 stops in POST so that row 6 arms over a running capture
        rows[5] = '{TRIG_LEVEL,  8'hff, 8'h81, 1, 10, 3};
        rows[6] = '{TRIG_RISE,   8'hc3, 8'h41, 1, 4, 0};
        rows[7] = '{TRIG_LEVEL,  8'hff, 8'h00, 2, 7, 0};
        void'($urandom(32'h5ef0_4ba5));
        checks    = 0;
        errors    = 0;
        cfg_mode  = TRIG_LEVEL;
        cfg_mask  = '0;
        cfg_value = '0;
        cur_match = is_match('0, cfg_mask, cfg_value);
        rst_n   <= 1'b0;
        probe_i <= '0;
        mask_i  <= '0;
        value_i <= '0;
        mode_i  <= TRIG_LEVEL;
        arm_i   <= 1'b0;
        rd_i    <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(armed_o, 1'b0, "armed_o after reset");
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(rd_empty_o, 1'b1, "rd_empty_o after reset");
        check_count(rd_count_o, '0, "rd_count_o after reset");
        // reads while idle must not pop
        repeat (3) step(sample_t'($urandom), 1'b0, 1'b1);
        @(negedge clk);
        check_count(rd_count_o, '0, "rd_count_o after rd_i in IDLE");
        $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (int r = 0; r < 8; r++) begin
            errs_at   = errors;
            cfg_mode  = rows[r].mode;
            cfg_mask  = rows[r].mask;
            cfg_value = rows[r].value;
            repeat (rows[r].idle) step(miss(sample_t'($urandom)), 1'b0, 1'b0);
            step(miss(sample_t'($urandom)), 1'b1, 1'b0);
            window.delete();
            exp_q.delete();
            n = 0;
            // rd_i toggles at random while armed and must be ignored
            while (exp_q.size() == 0 && n < 40) begin
                p = (n == rows[r].pos) ? cfg_value : miss(sample_t'($urandom));
                step(p, 1'b0, 1'($urandom));
                if (cur_hit) begin
                    exp_q = window;
                    exp_q.push_back(p);
                end else begin
                    window.push_back(p);
                    if (window.size() > `LA_PRE_DEPTH) begin
                        window.delete(0);
                    end
                end
                n++;
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("test %0d: the model saw no trigger within 40 samples", r);
                continue;
            end
            if (rows[r].abort_at > 0) begin
                // reads in POST must leave the stored count alone
                repeat (rows[r].abort_at) step(sample_t'($urandom), 1'b0, 1'b1);
                @(negedge clk);
                check_flag(armed_o, 1'b1, "armed_o in POST");
                check_count(rd_count_o, `LA_FIFO_AW'(exp_q.size() + rows[r].abort_at - 1),
                            "rd_count_o after rd_i in POST");
                $display("test %0d %s: left in POST for re-arm, %s", r, cfg_mode.name(),
                         (errors == errs_at) ? "ok" : "mismatch");
                continue;
            end
            // post-trigger samples and then the wait for done_o
            cnt      = 0;
            got_done = 1'b0;
            while (!got_done && cnt < 12) begin
                p = sample_t'($urandom);
                cnt++;
                if (cnt <= `LA_POST_DEPTH) begin
                    step(p, 1'b0, 1'($urandom));
                    exp_q.push_back(p);
                end else begin
                    step(p, 1'b0, 1'b0);
                end
                @(negedge clk);
                got_done = done_o;
            end
            if (!got_done) begin
                errors++;
                $display("test %0d: timeout waiting for done_o", r);
                continue;
            end
            check_count(`LA_FIFO_AW'(cnt), `LA_FIFO_AW'(`LA_POST_DEPTH + 1), "clocks to done_o");
            check_count(rd_count_o, `LA_FIFO_AW'(exp_q.size()), "stored sample count");
            check_flag(armed_o, 1'b0, "armed_o in DONE");
            // one rd_i pulse per entry and the next head one cycle later
            foreach (exp_q[i]) begin
                check_sample(rd_data_o, exp_q[i], $sformatf("readout sample %0d", i));
                step(sample_t'($urandom), 1'b0, 1'b1);
                step(sample_t'($urandom), 1'b0, 1'b0);
                @(negedge clk);
            end
            n = 0;
            while (!rd_empty_o && n < 4) begin
                step(sample_t'($urandom), 1'b0, 1'b0);
                @(negedge clk);
                n++;
            end
            if (!rd_empty_o) begin
                errors++;
                $display("test %0d: rd_empty_o still low after the readout", r);
            end
            $display("test %0d %s: %0d samples, %s", r, cfg_mode.name(), exp_q.size(),
                     (errors == errs_at) ? "ok" : "mismatch");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- la_capture_top.f
+incdir+common
common/la_pkg.sv
hw/la_fifo_v3.sv
hw/la_trigger_unit.sv
hw/la_capture_ctrl.sv
hw/la_capture_top.sv
verif/la_capture_sva.sv
verif/la_capture_tb.sv

//--- run_sim.sh
#!/bin/bash
# build the capture path testbench with Verilator, run it and check the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module la_capture_tb \
    -f la_capture_top.f \
    -o Vla_capture_tb

./obj_dir/Vla_capture_tb 2>&1 | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
